//--- fpAddSubPkg.sv
// --------------------------------------------------------------------------
// Shared types and constants for the pipelined floating-point adder
// --------------------------------------------------------------------------
`default_nettype none

package fpAddSubPkg;

	// Operand class after decode, subnormals land in Zero
	typedef enum logic [1:0]
	{
		Norm = 2'd0,
		Zero = 2'd1,
		Inf  = 2'd2,
		Nan  = 2'd3
	} tFpClass;

	// Carried from unpack to pack alongside the datapath
	typedef struct packed
	{
		logic    cValid;      // Stage valid
		logic    isSpecial;   // Result bypasses the datapath
		tFpClass specialKind; // Forced result class
		logic    specialSign;
	} tSpecialInfo;

	// Guard, round and sticky below the mantissa LSB
	localparam int cGuardBits = 3;

	// Enabled cycles from accept to o_Valid
	localparam int cLatency = 6;

	// Special info travels through align and normalize/round
	localparam int cInfoDepth = 4;

endpackage

`default_nettype wire

//--- mFpDelayLine.sv
// --------------------------------------------------------------------------
// Enable-qualified register chain for an arbitrary payload type
// --------------------------------------------------------------------------
`default_nettype none

module mFpDelayLine
#(
	parameter type tPayload = logic,
	parameter int pDepth = 2
)
(
	input logic i_Clk,
	input logic i_ARst,
	input logic i_ClkEn,
	input tPayload i_Data,
	output tPayload o_Data
);
	tPayload rStage [pDepth];

	// Cleared on reset so any valid bit inside drops
	always_ff @(posedge i_Clk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			for (int i = 0; i < pDepth; i++)
				rStage[i] <= '0;
		end
		else if (i_ClkEn)
		begin
			rStage[0] <= i_Data;
			for (int i = 1; i < pDepth; i++)
				rStage[i] <= rStage[i-1];
		end
	end

	assign o_Data = rStage[pDepth-1];

endmodule

`default_nettype wire

//--- mFpUnpack.sv
// --------------------------------------------------------------------------
// Input stage: field split, classify, magnitude order, exponent difference
// --------------------------------------------------------------------------
`default_nettype none

module mFpUnpack
	import fpAddSubPkg::*;
#(
	parameter int pExpW = 8,
	parameter int pManW = 23,
	localparam int cWordW = pExpW + pManW + 1,
	localparam int cSigW = pManW + 1 + cGuardBits,
	localparam int cDistW = $clog2(cSigW + 1)
)
(
	input logic i_Clk,
	input logic i_ARst,
	input logic i_ClkEn,
	input logic i_Valid,
	input logic i_SubNotAdd,
	input logic [cWordW-1:0] i_OpA,
	input logic [cWordW-1:0] i_OpB,
	output logic [cSigW-1:0] o_SigLarge,
	output logic [cSigW-1:0] o_SigSmall,
	output logic [pExpW-1:0] o_ExpLarge,
	output logic [cDistW-1:0] o_ShiftDist,
	output logic o_Sign,
	output logic o_EffSub,
	output tSpecialInfo o_Info
);
	logic signA, signB;
	logic [pExpW-1:0] expA, expB, expDiff;
	tFpClass classA, classB;
	logic normA, normB;
	logic [cSigW-1:0] sigA, sigB;
	logic aLarger, effSub;
	tSpecialInfo info;

	function automatic tFpClass classifyOp(
		input logic [pExpW-1:0] exp,
		input logic [pManW-1:0] man
	);
		if (exp == '0)
			return Zero; // Subnormal flushed
		else if (exp != '1)
			return Norm;
		else if (man != '0)
			return Nan;
		else
			return Inf;
	endfunction

	assign signA = i_OpA[cWordW-1];
	assign signB = i_OpB[cWordW-1] ^ i_SubNotAdd; // B as seen by an add
	assign expA = i_OpA[cWordW-2:pManW];
	assign expB = i_OpB[cWordW-2:pManW];
	assign classA = classifyOp(expA, i_OpA[pManW-1:0]);
	assign classB = classifyOp(expB, i_OpB[pManW-1:0]);
	assign normA = (classA == Norm);
	assign normB = (classB == Norm);

	// Hidden bit only for normals, zeros carry an empty significand
	assign sigA = {normA, i_OpA[pManW-1:0] & {pManW{normA}}, {cGuardBits{1'b0}}};
	assign sigB = {normB, i_OpB[pManW-1:0] & {pManW{normB}}, {cGuardBits{1'b0}}};

	// Exponent first, then significand
	assign aLarger = {expA, sigA} >= {expB, sigB};
	assign expDiff = aLarger ? expA - expB : expB - expA;
	assign effSub = signA ^ signB;

	always_comb
	begin
		info = '0;
		info.cValid = i_Valid;
		info.specialKind = Norm;
		if (classA == Nan || classB == Nan || (classA == Inf && classB == Inf && effSub))
		begin
			info.isSpecial = 1'b1;
			info.specialKind = Nan;
		end
		else if (classA == Inf || classB == Inf)
		begin
			info.isSpecial = 1'b1;
			info.specialKind = Inf;
			info.specialSign = (classA == Inf) ? signA : signB;
		end
		else if (classA == Zero && classB == Zero)
		begin
			// Negative only when both zeros are negative after the op
			info.isSpecial = 1'b1;
			info.specialKind = Zero;
			info.specialSign = signA & signB;
		end
	end

	always_ff @(posedge i_Clk or posedge i_ARst)
	begin
		if (i_ARst)
			o_Info <= '0;
		else if (i_ClkEn)
			o_Info <= info;
	end

	always_ff @(posedge i_Clk)
	begin
		if (i_ClkEn)
		begin
			o_SigLarge <= aLarger ? sigA : sigB;
			o_SigSmall <= aLarger ? sigB : sigA;
			o_ExpLarge <= aLarger ? expA : expB;
			o_Sign <= aLarger ? signA : signB;
			o_EffSub <= effSub;
			// Anything past the significand width is all sticky
			o_ShiftDist <= (expDiff > cSigW) ? cDistW'(cSigW) : cDistW'(expDiff);
		end
	end

endmodule

`default_nettype wire

//--- mFpAlign.sv
// --------------------------------------------------------------------------
// Alignment shift with sticky collapse, then significand add or subtract
// --------------------------------------------------------------------------
`default_nettype none

module mFpAlign
	import fpAddSubPkg::*;
#(
	parameter int pExpW = 8,
	parameter int pManW = 23,
	localparam int cSigW = pManW + 1 + cGuardBits,
	localparam int cDistW = $clog2(cSigW + 1)
)
(
	input logic i_Clk,
	input logic i_ClkEn,
	input logic [cSigW-1:0] i_SigLarge,
	input logic [cSigW-1:0] i_SigSmall,
	input logic [cDistW-1:0] i_ShiftDist,
	input logic i_EffSub,
	output logic [cSigW:0] o_Sum
);
	logic [2*cSigW-1:0] padded;
	logic sticky;
	logic [cSigW-1:0] shiftedQ;
	logic [cSigW-1:0] largeQ;
	logic effSubQ;

	if (pExpW < 2 || pManW < 2)
	begin : gWidthCheck
		$error("mFpAlign: exponent and mantissa need at least two bits each");
	end

	// Lower half catches every bit shifted out
	assign padded = {i_SigSmall, {cSigW{1'b0}}} >> i_ShiftDist;
	assign sticky = |padded[cSigW-1:0];

	// First cycle, aligned operand with sticky folded into the LSB
	always_ff @(posedge i_Clk)
	begin
		if (i_ClkEn)
		begin
			shiftedQ <= padded[2*cSigW-1:cSigW] | cSigW'(sticky);
			largeQ <= i_SigLarge;
			effSubQ <= i_EffSub;
		end
	end

	// Second cycle, larger magnitude first so the difference stays positive
	always_ff @(posedge i_Clk)
	begin
		if (i_ClkEn)
		begin
			if (effSubQ)
				o_Sum <= {1'b0, largeQ} - {1'b0, shiftedQ};
			else
				o_Sum <= {1'b0, largeQ} + {1'b0, shiftedQ};
		end
	end

endmodule

`default_nettype wire

//--- mFpNormRound.sv
// --------------------------------------------------------------------------
// Leading-zero normalization and round to nearest even
// --------------------------------------------------------------------------
`default_nettype none

module mFpNormRound
	import fpAddSubPkg::*;
#(
	parameter int pExpW = 8,
	parameter int pManW = 23,
	localparam int cSigW = pManW + 1 + cGuardBits,
	localparam int cLzW = $clog2(cSigW + 1)
)
(
	input logic i_Clk,
	input logic i_ClkEn,
	input logic [cSigW:0] i_Sum,
	input logic [pExpW-1:0] i_ExpLarge,
	input logic i_Sign,
	output logic [pManW-1:0] o_Mant,
	output logic signed [pExpW+1:0] o_ExpWide,
	output logic o_IsZero,
	output logic o_Sign
);
	logic [cLzW-1:0] lzCount;
	logic signed [pExpW+1:0] expExt, lzExt, normExp, normExpQ;
	logic [cSigW-1:0] normSig, normSigQ;
	logic signQ, zeroQ;
	logic guardBit, restBits, lsbBit, roundUp;
	logic [pManW:0] mantRnd;

	// Position of the highest set bit below the carry
	always_comb
	begin
		lzCount = cLzW'(cSigW);
		for (int i = 0; i < cSigW; i++)
			if (i_Sum[i])
				lzCount = cLzW'(cSigW - 1 - i);
	end

	assign expExt = {2'b00, i_ExpLarge};
	assign lzExt = (pExpW + 2)'(lzCount);

	always_comb
	begin
		if (i_Sum[cSigW])
		begin
			// Carry out, one right shift keeping the lost bit as sticky
			normSig = {i_Sum[cSigW:2], i_Sum[1] | i_Sum[0]};
			normExp = expExt + 1;
		end
		else
		begin
			normSig = i_Sum[cSigW-1:0] << lzCount;
			normExp = expExt - lzExt;
		end
	end

	always_ff @(posedge i_Clk)
	begin
		if (i_ClkEn)
		begin
			normSigQ <= normSig;
			normExpQ <= normExp;
			zeroQ <= (i_Sum == '0);
			signQ <= i_Sign;
		end
	end

	// Guard, then round and sticky collapsed, ties go to the even LSB
	assign guardBit = normSigQ[cGuardBits-1];
	assign restBits = |normSigQ[cGuardBits-2:0];
	assign lsbBit = normSigQ[cGuardBits];
	assign roundUp = guardBit & (restBits | lsbBit);
	assign mantRnd = {1'b0, normSigQ[cSigW-2:cGuardBits]} + (pManW + 1)'(roundUp);

	always_ff @(posedge i_Clk)
	begin
		if (i_ClkEn)
		begin
			o_Mant <= mantRnd[pManW-1:0]; // All zeros on rollover
			o_ExpWide <= mantRnd[pManW] ? normExpQ + 1 : normExpQ;
			o_IsZero <= zeroQ;
			o_Sign <= signQ;
		end
	end

endmodule

`default_nettype wire

//--- mFpPack.sv
// --------------------------------------------------------------------------
// Output stage: special results, range flags and result packing
// --------------------------------------------------------------------------
`default_nettype none

module mFpPack
	import fpAddSubPkg::*;
#(
	parameter int pExpW = 8,
	parameter int pManW = 23,
	localparam int cWordW = pExpW + pManW + 1
)
(
	input logic i_Clk,
	input logic i_ARst,
	input logic i_ClkEn,
	input tSpecialInfo i_Info,
	input logic [pManW-1:0] i_Mant,
	input logic signed [pExpW+1:0] i_ExpWide,
	input logic i_IsZero,
	input logic i_Sign,
	output logic o_Valid,
	output logic [cWordW-1:0] o_Result,
	output logic o_Nan,
	output logic o_Overflow,
	output logic o_Underflow
);
	localparam logic [pExpW-1:0] cExpOnes = '1;
	localparam logic [cWordW-1:0] cQuietNan = {1'b0, cExpOnes, 1'b1, {(pManW-1){1'b0}}};

	logic [cWordW-1:0] result;
	logic nanFlag, ovfFlag, udfFlag;

	always_comb
	begin
		result = {i_Sign, i_ExpWide[pExpW-1:0], i_Mant};
		nanFlag = 1'b0;
		ovfFlag = 1'b0;
		udfFlag = 1'b0;
		if (i_Info.isSpecial)
		begin
			case (i_Info.specialKind)
				Nan:
				begin
					result = cQuietNan;
					nanFlag = 1'b1;
				end
				Inf:
					result = {i_Info.specialSign, cExpOnes, {pManW{1'b0}}};
				default:
					result = {i_Info.specialSign, {(pExpW + pManW){1'b0}}};
			endcase
		end
		else if (i_IsZero)
			result = '0; // Exact cancellation gives +0
		else if (i_ExpWide >= $signed({2'b00, cExpOnes}))
		begin
			result = {i_Sign, cExpOnes, {pManW{1'b0}}};
			ovfFlag = 1'b1;
		end
		else if (i_ExpWide <= 0)
		begin
			result = {i_Sign, {(pExpW + pManW){1'b0}}};
			udfFlag = 1'b1;
		end
	end

	always_ff @(posedge i_Clk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			o_Valid <= 1'b0;
			o_Nan <= 1'b0;
			o_Overflow <= 1'b0;
			o_Underflow <= 1'b0;
		end
		else if (i_ClkEn)
		begin
			o_Valid <= i_Info.cValid;
			o_Nan <= nanFlag & i_Info.cValid;
			o_Overflow <= ovfFlag & i_Info.cValid;
			o_Underflow <= udfFlag & i_Info.cValid;
		end
	end

	always_ff @(posedge i_Clk)
	begin
		if (i_ClkEn)
			o_Result <= result;
	end

endmodule

`default_nettype wire

//--- mFpAddSub.sv
// --------------------------------------------------------------------------
// Pipelined floating-point adder/subtractor top level
// --------------------------------------------------------------------------
`default_nettype none

module mFpAddSub
	import fpAddSubPkg::*;
#(
	parameter int pExpW = 8,
	parameter int pManW = 23,
	localparam int cWordW = pExpW + pManW + 1,
	localparam int cSigW = pManW + 1 + cGuardBits,
	localparam int cDistW = $clog2(cSigW + 1)
)
(
	input logic i_Clk,
	input logic i_ARst,
	input logic i_ClkEn,
	input logic i_Valid,
	input logic i_SubNotAdd,
	input logic [cWordW-1:0] i_OpA,
	input logic [cWordW-1:0] i_OpB,
	output logic o_Valid,
	output logic [cWordW-1:0] o_Result,
	output logic o_Nan,
	output logic o_Overflow,
	output logic o_Underflow
);
	localparam int cAlignDepth = 2;

	logic [cSigW-1:0] sigLarge, sigSmall;
	logic [pExpW-1:0] expLarge;
	logic [cDistW-1:0] shiftDist;
	logic sign, effSub;
	tSpecialInfo infoUnpack, infoPack;
	logic [cSigW:0] sum;
	logic [pExpW+1:0] expSignDly; // Sign, effective subtract, larger exponent
	logic [pManW-1:0] mant;
	logic signed [pExpW+1:0] expWide;
	logic isZero, signRound;

	// Unpack, align, normalize/round and pack must add up to the latency
	if (1 + cAlignDepth + 2 + 1 != cLatency || cAlignDepth + 2 != cInfoDepth)
	begin : gDepthCheck
		$error("mFpAddSub: stage depths disagree with the latency constants");
	end

	mFpUnpack #(.pExpW(pExpW), .pManW(pManW)) uUnpack
	(
		.i_Clk(i_Clk), .i_ARst(i_ARst), .i_ClkEn(i_ClkEn),
		.i_Valid(i_Valid), .i_SubNotAdd(i_SubNotAdd),
		.i_OpA(i_OpA), .i_OpB(i_OpB),
		.o_SigLarge(sigLarge), .o_SigSmall(sigSmall),
		.o_ExpLarge(expLarge), .o_ShiftDist(shiftDist),
		.o_Sign(sign), .o_EffSub(effSub), .o_Info(infoUnpack)
	);

	mFpAlign #(.pExpW(pExpW), .pManW(pManW)) uAlign
	(
		.i_Clk(i_Clk), .i_ClkEn(i_ClkEn),
		.i_SigLarge(sigLarge), .i_SigSmall(sigSmall),
		.i_ShiftDist(shiftDist), .i_EffSub(effSub),
		.o_Sum(sum)
	);

	mFpDelayLine #(.tPayload(logic [pExpW+1:0]), .pDepth(cAlignDepth)) uExpDelay
	(
		.i_Clk(i_Clk), .i_ARst(i_ARst), .i_ClkEn(i_ClkEn),
		.i_Data({sign, effSub, expLarge}),
		.o_Data(expSignDly)
	);

	mFpDelayLine #(.tPayload(tSpecialInfo), .pDepth(cInfoDepth)) uInfoDelay
	(
		.i_Clk(i_Clk), .i_ARst(i_ARst), .i_ClkEn(i_ClkEn),
		.i_Data(infoUnpack),
		.o_Data(infoPack)
	);

	mFpNormRound #(.pExpW(pExpW), .pManW(pManW)) uNormRound
	(
		.i_Clk(i_Clk), .i_ClkEn(i_ClkEn),
		.i_Sum(sum),
		.i_ExpLarge(expSignDly[pExpW-1:0]),
		.i_Sign(expSignDly[pExpW+1]),
		.o_Mant(mant), .o_ExpWide(expWide),
		.o_IsZero(isZero), .o_Sign(signRound)
	);

	mFpPack #(.pExpW(pExpW), .pManW(pManW)) uPack
	(
		.i_Clk(i_Clk), .i_ARst(i_ARst), .i_ClkEn(i_ClkEn),
		.i_Info(infoPack), .i_Mant(mant), .i_ExpWide(expWide),
		.i_IsZero(isZero), .i_Sign(signRound),
		.o_Valid(o_Valid), .o_Result(o_Result),
		.o_Nan(o_Nan), .o_Overflow(o_Overflow), .o_Underflow(o_Underflow)
	);

endmodule

`default_nettype wire

//--- fpAddSub_chk.sv
// --------------------------------------------------------------------------
// Output property checks for the floating-point adder, bound into the top
// --------------------------------------------------------------------------
`default_nettype none

module mFpAddSubChk
#(
	parameter int pExpW = 8,
	parameter int pManW = 23
)
(
	input logic i_Clk,
	input logic i_ARst,
	input logic o_Valid,
	input logic [pExpW+pManW:0] o_Result,
	input logic o_Nan,
	input logic o_Overflow,
	input logic o_Underflow
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [pExpW+pManW:0] cQuietNan = {1'b0, {pExpW{1'b1}}, 1'b1, {(pManW-1){1'b0}}};

	aFlagsExclusive: assert property (@(posedge i_Clk) disable iff (i_ARst)
		!(o_Overflow && o_Underflow))
		else $error("Overflow and underflow flags high together");

	aNanCanonical: assert property (@(posedge i_Clk) disable iff (i_ARst)
		o_Nan |-> (o_Result == cQuietNan))
		else $error("NaN flag without the canonical quiet NaN");

	aNoValidInReset: assert property (@(posedge i_Clk) i_ARst |-> !o_Valid)
		else $error("Valid high during reset");

endmodule

bind mFpAddSub mFpAddSubChk #(.pExpW(pExpW), .pManW(pManW)) uChk
(
	.i_Clk(i_Clk), .i_ARst(i_ARst), .o_Valid(o_Valid), .o_Result(o_Result),
	.o_Nan(o_Nan), .o_Overflow(o_Overflow), .o_Underflow(o_Underflow)
);

`default_nettype wire

//--- fpRefModel.svh
// --------------------------------------------------------------------------
// Bit-exact integer model of the adder, result and flag trio {nan,ovf,udf}
// --------------------------------------------------------------------------
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

localparam int cRefSigW = cManW + 4; // Hidden bit, mantissa, guard/round/sticky

function automatic tFpClass refClass(input logic [cExpW-1:0] e, input logic [cManW-1:0] m);
	if (e == '0)
		return Zero; // Subnormals flush
	if (e == '1)
		return (m == '0) ? Inf : Nan;
	return Norm;
endfunction

function automatic logic [cWordW+2:0] refAddSub(input logic [cWordW-1:0] a,
	input logic [cWordW-1:0] b, input logic sub);
	logic sa, sb, sl, sticky, up;
	tFpClass ca, cb;
	int ea, eb, el, d;
	longint ma, mb, ml, ms, sum, man, mask;
	sa = a[cWordW-1];
	sb = b[cWordW-1] ^ sub; // Sign of B as added
	ea = int'(a[cWordW-2:cManW]);
	eb = int'(b[cWordW-2:cManW]);
	ca = refClass(a[cWordW-2:cManW], a[cManW-1:0]);
	cb = refClass(b[cWordW-2:cManW], b[cManW-1:0]);
	if (ca == Nan || cb == Nan || (ca == Inf && cb == Inf && sa != sb))
		return {1'b0, {cExpW{1'b1}}, 1'b1, {(cManW-1){1'b0}}, 3'b100};
	if (ca == Inf)
		return {sa, {cExpW{1'b1}}, {cManW{1'b0}}, 3'b000};
	if (cb == Inf)
		return {sb, {cExpW{1'b1}}, {cManW{1'b0}}, 3'b000};
	if (ca == Zero && cb == Zero)
		return {sa & sb, {(cWordW-1){1'b0}}, 3'b000};
	ma = (ca == Norm) ? longint'({1'b1, a[cManW-1:0]}) << 3 : 0;
	mb = (cb == Norm) ? longint'({1'b1, b[cManW-1:0]}) << 3 : 0;
	if (ea > eb || (ea == eb && ma >= mb))
	begin
		el = ea; ml = ma; ms = mb; sl = sa; d = ea - eb;
	end
	else
	begin
		el = eb; ml = mb; ms = ma; sl = sb; d = eb - ea;
	end
	if (d > cRefSigW)
		d = cRefSigW;
	sticky = (ms & ((longint'(1) << d) - 1)) != 0; // Collapse lost bits
	ms = (ms >> d) | longint'(sticky);
	sum = (sa != sb) ? ml - ms : ml + ms;
	if (sum == 0)
		return '0;
	if (sum >= (longint'(1) << cRefSigW))
	begin
		sum = (sum >> 1) | (sum & 1);
		el++;
	end
	else
		while (sum < (longint'(1) << (cRefSigW - 1)))
		begin
			sum = sum << 1;
			el--;
		end
	up = sum[2] & (sum[3] | sum[1] | sum[0]); // Nearest, ties to even
	mask = (longint'(1) << cManW) - 1;
	man = ((sum >> 3) & mask) + longint'(up);
	if (man > mask)
	begin
		man = 0;
		el++;
	end
	if (el >= (1 << cExpW) - 1)
		return {sl, {cExpW{1'b1}}, {cManW{1'b0}}, 3'b010};
	if (el <= 0)
		return {sl, {(cWordW-1){1'b0}}, 3'b001};
	return {sl, el[cExpW-1:0], man[cManW-1:0], 3'b000};
endfunction

`endif

//--- tbFpAddSub.sv
// --------------------------------------------------------------------------
// Adder testbench with LFSR stimulus, model queue, compare tasks and watchdog
// --------------------------------------------------------------------------
`default_nettype none

module tbFpAddSub
	import fpAddSubPkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int cExpW = 8;
	localparam int cManW = 23;
	localparam int cWordW = cExpW + cManW + 1;
	localparam int cTotalOps = 200 + 100 + 100 + 100 + 150 + 50;

	`include "fpRefModel.svh"

	logic i_Clk = 1'b0;
	logic i_ARst, i_ClkEn, i_Valid, i_SubNotAdd;
	logic [cWordW-1:0] i_OpA, i_OpB;
	logic o_Valid, o_Nan, o_Overflow, o_Underflow;
	logic [cWordW-1:0] o_Result;

	logic [31:0] lfsrState = 32'd27;
	logic [cWordW+2:0] expQ[$];
	int accQ[$];
	int enCount = 0;
	logic lastEn = 1'b0;
	int errCount = 0;
	int checkCount = 0;
	int testCount = 0;

	mFpAddSub #(.pExpW(cExpW), .pManW(cManW)) i_dut
	(
		.i_Clk(i_Clk), .i_ARst(i_ARst), .i_ClkEn(i_ClkEn),
		.i_Valid(i_Valid), .i_SubNotAdd(i_SubNotAdd),
		.i_OpA(i_OpA), .i_OpB(i_OpB),
		.o_Valid(o_Valid), .o_Result(o_Result),
		.o_Nan(o_Nan), .o_Overflow(o_Overflow), .o_Underflow(o_Underflow)
	);

	always #4 i_Clk = ~i_Clk;

	// One Galois step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'hB4BCD35C : lfsrState >> 1;
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	function automatic logic [cWordW-1:0] randNormal(input int expLo, input int expHi);
		int e;
		e = expLo + int'(randBits(8)) % (expHi - expLo + 1);
		return {randBits(1) == 1, e[cExpW-1:0], cManW'(randBits(cManW))};
	endfunction

	function automatic logic [cWordW-1:0] pickSpecial();
		case (randBits(3))
			0: return 32'h7FC00000;
			1: return 32'hFF800001; // Negative signalling NaN
			2: return 32'h7F800000;
			3: return 32'hFF800000;
			4: return 32'h00000000;
			5: return 32'h80000000;
			6: return 32'h00000001; // Subnormal
			default: return 32'h807FFFFF;
		endcase
	endfunction

	task automatic checkResult(input logic [cWordW-1:0] got, input logic [cWordW-1:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("[FAIL] %0t ns: result %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic checkFlags(input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp)
		begin
			errCount++;
			$display("[FAIL] %0t ns: flags nan/ovf/udf %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic checkLatency(input int got, input int exp);
		if (got != exp)
		begin
			errCount++;
			$display("[FAIL] %0t ns: latency %0d enabled cycles, expected %0d", $time, got, exp);
		end
	endtask

	// Holds the operation until an enabled edge takes it
	task automatic driveOp(input logic [cWordW-1:0] a, input logic [cWordW-1:0] b,
		input logic sub, input logic randEn);
		logic en;
		do
		begin
			@(posedge i_Clk);
			#1;
			en = randEn ? randBits(1) == 1 : 1'b1;
			i_OpA = a;
			i_OpB = b;
			i_SubNotAdd = sub;
			i_Valid = 1'b1;
			i_ClkEn = en;
		end
		while (!en);
		expQ.push_back(refAddSub(a, b, sub));
		accQ.push_back(enCount);
	endtask

	task automatic idleCycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge i_Clk);
			#1;
			i_Valid = 1'b0;
			i_ClkEn = 1'b1;
		end
	endtask

	task automatic finishTest(input string name, input int errBefore);
		idleCycles(1);
		while (expQ.size() != 0)
			@(posedge i_Clk);
		testCount++;
		$display("Test %0d %s: %0d errors", testCount, name, errCount - errBefore);
	endtask

	always @(posedge i_Clk)
	begin
		if (i_ClkEn)
			enCount <= enCount + 1;
		lastEn <= i_ClkEn;
	end

	// Registered outputs are stable at the falling edge
	always @(negedge i_Clk)
	begin : monitor
		logic [cWordW+2:0] exp;
		int acc;
		if (!i_ARst && lastEn && o_Valid)
		begin
			if (expQ.size() == 0)
			begin
				errCount++;
				$display("A result came out with no operation outstanding at %0t ns", $time);
			end
			else
			begin
				exp = expQ.pop_front();
				acc = accQ.pop_front();
				checkResult(o_Result, exp[cWordW+2:3]);
				checkFlags({o_Nan, o_Overflow, o_Underflow}, exp[2:0]);
				checkLatency(enCount - acc, cLatency);
			end
		end
	end

	initial
	begin
		#((cTotalOps * 20 + 50) * 8);
		$display("Watchdog expired before all results came back");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin : stimulus
		logic [cWordW-1:0] a, b;
		logic sub, s;
		int errBefore, e;
		i_ARst = 1'b1;
		i_ClkEn = 1'b0;
		i_Valid = 1'b0;
		i_SubNotAdd = 1'b0;
		i_OpA = '0;
		i_OpB = '0;
		repeat (8) @(posedge i_Clk);
		#1;
		i_ARst = 1'b0;

		errBefore = errCount;
		for (int i = 0; i < 200; i++)
		begin
			a = randNormal(1, 254);
			b = randBits(1) ? randNormal(1, 254) : {randBits(1) == 1, a[30:23] ^ 8'(randBits(3)),
				cManW'(randBits(cManW))}; // Close exponents half the time
			if (b[30:23] == 8'h00 || b[30:23] == 8'hFF)
				b[30:23] = 8'h80;
			driveOp(a, b, randBits(1) == 1, 1'b0);
		end
		finishTest("random normals", errBefore);

		errBefore = errCount;
		for (int i = 0; i < 100; i++)
		begin
			a = randNormal(30, 200);
			sub = randBits(1) == 1;
			e = int'(a[30:23]) + int'(randBits(2) % 3) - 1;
			b = {~a[31] ^ sub, e[7:0], a[22:0] ^ 23'(randBits(4))};
			if (randBits(2) == 0)
				b = {~a[31] ^ sub, a[30:0]}; // Exact cancellation
			driveOp(a, b, sub, 1'b0);
		end
		finishTest("cancellation", errBefore);

		errBefore = errCount;
		for (int i = 0; i < 100; i++)
		begin
			a = randBits(1) ? pickSpecial() : randNormal(1, 254);
			b = pickSpecial();
			if (randBits(1))
				driveOp(a, b, randBits(1) == 1, 1'b0);
			else
				driveOp(b, a, randBits(1) == 1, 1'b0);
		end
		finishTest("special operands", errBefore);

		errBefore = errCount;
		for (int i = 0; i < 100; i++)
		begin
			s = randBits(1) == 1;
			sub = randBits(1) == 1;
			if (randBits(1))
			begin
				a = {s, 8'hFE, cManW'(randBits(cManW))};
				b = {s ^ sub, 8'hFD + 8'(randBits(1)), cManW'(randBits(cManW))};
			end
			else
			begin
				a = {s, 8'h01 + 8'(randBits(1)), cManW'(randBits(cManW))};
				b = {~s ^ sub, 8'h01, cManW'(randBits(cManW))};
			end
			driveOp(a, b, sub, 1'b0);
		end
		finishTest("range limits", errBefore);

		errBefore = errCount;
		for (int i = 0; i < 150; i++)
			driveOp(randNormal(100, 160), randNormal(100, 160), randBits(1) == 1, 1'b1);
		finishTest("random clock enable", errBefore);

		errBefore = errCount;
		for (int i = 0; i < 50; i++)
		begin
			driveOp(randNormal(1, 254), randNormal(1, 254), randBits(1) == 1, 1'b0);
			idleCycles(int'(randBits(2)));
		end
		finishTest("latency", errBefore);

		$display("%0d tests, %0d results checked, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
fpAddSubPkg.sv
mFpDelayLine.sv
mFpUnpack.sv
mFpAlign.sv
mFpNormRound.sv
mFpPack.sv
mFpAddSub.sv
fpAddSub_chk.sv
tbFpAddSub.sv

//--- run.sh
#!/bin/sh
# Compile and run the adder testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tbFpAddSub \
	-f build.f -o simFpAddSub
./obj_dir/simFpAddSub > sim.log 2>&1 || true
cat sim.log
grep -q "TEST RESULT: PASS" sim.log
